/* flist.f */
cpuPkg.sv
pipeIf.sv
fetchUnit.sv
registerFile.sv
decodeStage.sv
executeStage.sv
memoryWriteback.sv
cpuTop.sv
tbCpu.sv

/* run.sh */
#!/bin/sh
# Builds and runs the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tbCpu -f flist.f -o simCpu

./obj_dir/simCpu > sim.log 2>&1 || true
cat sim.log

grep -q "Simulation PASSED" sim.log

/* tbCpu.sv */
`timescale 1ns/1ps

module tbCpu import cpuPkg::*; ();

    localparam int clkPeriod = 10;
    localparam int resetCycles = 5;
    localparam int cycleBudget = 200;
    localparam int testCount = 5;
    localparam int marginNs = 2000;
    localparam int seed = 50270;
    localparam logic [wordWidth-1:0] resetPc = '0;
    localparam logic [wordWidth-1:0] doneAddr = 32'h0000_03fc;

    logic clk;
    logic reset;
    logic [wordWidth-1:0] instrAddr;
    logic [wordWidth-1:0] instrData;
    logic [wordWidth-1:0] dataAddr;
    logic [wordWidth-1:0] dataWriteData;
    logic [wordWidth-1:0] dataReadData;
    logic dataReadEnable;
    logic dataWriteEnable;

    logic [wordWidth-1:0] imem [256];
    logic [wordWidth-1:0] dmem [256];
    logic [wordWidth-1:0] logAddr [$];
    logic [wordWidth-1:0] logData [$];
    logic [wordWidth-1:0] expAddr [$];
    logic [wordWidth-1:0] expData [$];
    logic readSeen;
    int progLen;
    int errors;

    cpuTop #(.resetPc(resetPc)) dut_i (
        .clk(clk),
        .reset(reset),
        .instrAddr(instrAddr),
        .instrData(instrData),
        .dataAddr(dataAddr),
        .dataWriteData(dataWriteData),
        .dataReadData(dataReadData),
        .dataReadEnable(dataReadEnable),
        .dataWriteEnable(dataWriteEnable)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    assign instrData = imem[instrAddr[9:2]];
    assign dataReadData = dmem[dataAddr[9:2]];

    // Data memory refills while reset is high; every store is logged
    always @(posedge clk) begin
        if (reset) begin
            for (int idx = 0; idx < 256; idx++) begin
                dmem[idx] <= 32'hda7a_0000 ^ (32'(idx) << 2);
            end
        end
        else if (dataWriteEnable) begin
            dmem[dataAddr[9:2]] <= dataWriteData;
            logAddr.push_back(dataAddr);
            logData.push_back(dataWriteData);
        end
        if (dataReadEnable) begin
            readSeen = 1'b1;
        end
    end

    initial begin
        #(testCount * cycleBudget * clkPeriod + marginNs);
        $display("Timeout: the tests did not finish in the expected time");
        $display("Simulation FAILED");
        $finish;
    end

    task automatic checkWord(input string name, input logic [wordWidth-1:0] seen,
                             input logic [wordWidth-1:0] expected);
        if (seen !== expected) begin
            $display("ERR %0t %s seen %h expected %h", $time, name, seen, expected);
            errors++;
        end
    endtask

    task automatic checkBit(input string name, input logic seen, input logic expected);
        if (seen !== expected) begin
            $display("ERR %0t %s seen %b expected %b", $time, name, seen, expected);
            errors++;
        end
    endtask

    function automatic logic [wordWidth-1:0] encodeR(input logic [5:0] funct, input int rs,
                                                     input int rt, input int rd);
        return {opSpecial, 5'(rs), 5'(rt), 5'(rd), 5'd0, funct};
    endfunction

    function automatic logic [wordWidth-1:0] encodeI(input logic [5:0] op, input int rs,
                                                     input int rt, input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic logic [wordWidth-1:0] encodeJ(input int wordIndex);
        return {opJ, 26'(wordIndex)};
    endfunction

    task automatic startProgram();
        for (int idx = 0; idx < 256; idx++) begin
            imem[idx] = '0;
        end
        progLen = 0;
        expAddr.delete();
        expData.delete();
    endtask

    task automatic emit(input logic [wordWidth-1:0] word);
        imem[progLen] = word;
        progLen++;
    endtask

    task automatic expectStore(input logic [wordWidth-1:0] addr,
                               input logic [wordWidth-1:0] data);
        expAddr.push_back(addr);
        expData.push_back(data);
    endtask

    // Final store of r0 marks the end of every program
    task automatic finishProgram();
        emit(encodeI(opSw, 0, 0, doneAddr[15:0]));
        expectStore(doneAddr, '0);
    endtask

    task automatic applyReset();
        reset = 1'b1;
        repeat (resetCycles) begin
            @(posedge clk);
            #1;
            checkBit("dataWriteEnable", dataWriteEnable, 1'b0);
            checkBit("dataReadEnable", dataReadEnable, 1'b0);
        end
        logAddr.delete();
        logData.delete();
        readSeen = 1'b0;
        reset = 1'b0;
        checkWord("instrAddr", instrAddr, resetPc);
    endtask

    task automatic runProgram();
        int cycles;
        bit finished;
        cycles = 0;
        finished = 1'b0;
        while (!finished && cycles < cycleBudget) begin
            @(posedge clk);
            #1;
            cycles++;
            if (logAddr.size() > 0 && logAddr[logAddr.size() - 1] == doneAddr) begin
                finished = 1'b1;
            end
        end
        if (!finished) begin
            $display("Program did not reach its final store within %0d cycles", cycleBudget);
            errors++;
        end
    endtask

    task automatic checkStores();
        if (logAddr.size() != expAddr.size()) begin
            $display("Wrong number of stores at %0t: %0d seen, %0d expected",
                     $time, logAddr.size(), expAddr.size());
            errors++;
        end
        for (int k = 0; k < expAddr.size() && k < logAddr.size(); k++) begin
            checkWord($sformatf("dataAddr[%0d]", k), logAddr[k], expAddr[k]);
            checkWord($sformatf("dataWriteData[%0d]", k), logData[k], expData[k]);
        end
    endtask

    task automatic runAndCheck();
        applyReset();
        runProgram();
        checkStores();
    endtask

    task automatic quietTest();
        logic [15:0] k;
        k = 16'($urandom());
        startProgram();
        emit(encodeI(opOri, 0, 1, k));
        emit(encodeR(fnAddu, 1, 1, 2));
        emit(encodeI(opSw, 0, 2, 16'h0040));
        expectStore(32'h40, {16'b0, k} + {16'b0, k});
        finishProgram();
        runAndCheck();
        checkBit("dataReadEnable", readSeen, 1'b0);
    endtask

    task automatic aluChainTest();
        logic [wordWidth-1:0] c0, c1;
        logic [wordWidth-1:0] expectVal [1:8];
        c0 = $urandom();
        c1 = $urandom();
        expectVal[1] = c0;
        expectVal[2] = c1;
        expectVal[3] = c0 + c1;
        expectVal[4] = expectVal[3] - c0;
        expectVal[5] = expectVal[4] & expectVal[3];
        expectVal[6] = expectVal[5] | c0;
        expectVal[7] = ($signed(expectVal[6]) < $signed(c1)) ? 32'd1 : 32'd0;
        expectVal[8] = ($signed(c1) < $signed(expectVal[6])) ? 32'd1 : 32'd0;
        startProgram();
        emit(encodeI(opLui, 0, 1, c0[31:16]));
        emit(encodeI(opOri, 1, 1, c0[15:0]));
        emit(encodeI(opLui, 0, 2, c1[31:16]));
        emit(encodeI(opOri, 2, 2, c1[15:0]));
        emit(encodeR(fnAddu, 1, 2, 3));
        emit(encodeR(fnSubu, 3, 1, 4));
        emit(encodeR(fnAnd, 4, 3, 5));
        emit(encodeR(fnOr, 5, 1, 6));
        emit(encodeR(fnSlt, 6, 2, 7));
        emit(encodeR(fnSlt, 2, 6, 8));
        for (int k = 1; k <= 8; k++) begin
            emit(encodeI(opSw, 0, k, 16'(32'h100 + 4 * k)));
            expectStore(32'(32'h100 + 4 * k), expectVal[k]);
        end
        finishProgram();
        runAndCheck();
    endtask

    task automatic loadUseTest();
        logic [wordWidth-1:0] c;
        logic [15:0] k;
        c = $urandom();
        k = 16'($urandom());
        startProgram();
        emit(encodeI(opLui, 0, 1, c[31:16]));
        emit(encodeI(opOri, 1, 1, c[15:0]));
        emit(encodeI(opOri, 0, 4, k));
        emit(encodeI(opSw, 0, 1, 16'h0200));
        emit(encodeI(opLw, 0, 2, 16'h0200));
        emit(encodeR(fnAddu, 2, 4, 3));
        emit(encodeI(opSw, 0, 3, 16'h0204));
        // Store data taken straight from a load
        emit(encodeI(opLw, 0, 5, 16'h0200));
        emit(encodeI(opSw, 0, 5, 16'h0208));
        expectStore(32'h200, c);
        expectStore(32'h204, c + {16'b0, k});
        expectStore(32'h208, c);
        finishProgram();
        runAndCheck();
    endtask

    task automatic branchTest();
        logic [15:0] m;
        m = 16'($urandom());
        startProgram();
        emit(encodeI(opOri, 0, 1, m));
        emit(encodeI(opOri, 0, 2, m));
        emit(encodeI(opBeq, 1, 2, 16'd2));
        emit(encodeI(opSw, 0, 1, 16'h0300));
        emit(encodeI(opSw, 0, 1, 16'h0304));
        emit(encodeI(opBne, 1, 2, 16'd4));
        emit(encodeI(opSw, 0, 2, 16'h0308));
        emit(encodeI(opSw, 0, 2, 16'h030c));
        emit(encodeJ(11));
        emit(encodeI(opSw, 0, 1, 16'h0310));
        emit(encodeI(opSw, 0, 1, 16'h0314));
        expectStore(32'h300, {16'b0, m});
        expectStore(32'h308, {16'b0, m});
        expectStore(32'h30c, {16'b0, m});
        expectStore(32'h310, {16'b0, m});
        finishProgram();
        runAndCheck();
    endtask

    task automatic zeroRegTest();
        logic [15:0] k;
        k = 16'($urandom()) | 16'h0001;
        startProgram();
        emit(encodeI(opOri, 0, 1, k));
        emit(encodeI(opOri, 0, 0, k));
        emit(encodeI(opSw, 0, 0, 16'h0080));
        emit(encodeR(fnAddu, 1, 1, 0));
        emit(encodeI(opLui, 0, 0, 16'habcd));
        emit(encodeI(opSw, 0, 0, 16'h0084));
        emit(encodeR(fnAddu, 0, 1, 5));
        emit(encodeI(opSw, 0, 5, 16'h0088));
        expectStore(32'h80, '0);
        expectStore(32'h84, '0);
        expectStore(32'h88, {16'b0, k});
        finishProgram();
        runAndCheck();
    endtask

    initial begin
        reset = 1'b1;
        errors = 0;
        readSeen = 1'b0;
        progLen = 0;
        void'($urandom(seed));
        quietTest();
        aluChainTest();
        loadUseTest();
        branchTest();
        zeroRegTest();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end
        else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* cpuTop.sv */
`timescale 1ns/1ps

module cpuTop import cpuPkg::*; #(
    parameter logic [wordWidth-1:0] resetPc = '0
) (
    input  logic clk,
    input  logic reset,
    output logic [wordWidth-1:0] instrAddr,
    input  logic [wordWidth-1:0] instrData,
    output logic [wordWidth-1:0] dataAddr,
    output logic [wordWidth-1:0] dataWriteData,
    input  logic [wordWidth-1:0] dataReadData,
    output logic dataReadEnable,
    output logic dataWriteEnable
);

    logic stall;
    logic redirect;
    logic [wordWidth-1:0] redirectPc;
    logic [regAddrWidth-1:0] readAddr1;
    logic [regAddrWidth-1:0] readAddr2;
    logic [wordWidth-1:0] readData1;
    logic [wordWidth-1:0] readData2;
    logic [regAddrWidth-1:0] writeAddr;
    logic [wordWidth-1:0] writeData;

    decodeExIf dxBus ();
    exMemIf xmBus ();
    bypassIf bypassBus ();

    fetchUnit #(.resetPc(resetPc)) fetchInst (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .redirect(redirect),
        .redirectPc(redirectPc),
        .instrAddr(instrAddr)
    );

    registerFile regFile (
        .clk(clk),
        .reset(reset),
        .readAddr1(readAddr1),
        .readAddr2(readAddr2),
        .readData1(readData1),
        .readData2(readData2),
        .writeAddr(writeAddr),
        .writeData(writeData)
    );

    decodeStage decode (
        .clk(clk),
        .reset(reset),
        .instrData(instrData),
        .instrAddr(instrAddr),
        .stall(stall),
        .redirect(redirect),
        .redirectPc(redirectPc),
        .readAddr1(readAddr1),
        .readAddr2(readAddr2),
        .readData1(readData1),
        .readData2(readData2),
        .toExecute(dxBus),
        .bypass(bypassBus)
    );

    executeStage execute (
        .clk(clk),
        .reset(reset),
        .fromDecode(dxBus),
        .toMemory(xmBus),
        .bypass(bypassBus)
    );

    memoryWriteback memWb (
        .clk(clk),
        .reset(reset),
        .fromExecute(xmBus),
        .bypass(bypassBus),
        .dataAddr(dataAddr),
        .dataWriteData(dataWriteData),
        .dataReadData(dataReadData),
        .dataReadEnable(dataReadEnable),
        .dataWriteEnable(dataWriteEnable),
        .writeAddr(writeAddr),
        .writeData(writeData)
    );

endmodule

/* memoryWriteback.sv */
`timescale 1ns/1ps

module memoryWriteback import cpuPkg::*; (
    input  logic clk,
    input  logic reset,
    exMemIf.memorySide fromExecute,
    bypassIf.lateSide bypass,
    output logic [wordWidth-1:0] dataAddr,
    output logic [wordWidth-1:0] dataWriteData,
    input  logic [wordWidth-1:0] dataReadData,
    output logic dataReadEnable,
    output logic dataWriteEnable,
    output logic [regAddrWidth-1:0] writeAddr,
    output logic [wordWidth-1:0] writeData
);

    logic mValid;
    logic mMemRead;
    logic mMemWrite;
    logic [regAddrWidth-1:0] mDest;
    logic [wordWidth-1:0] mAluResult;
    logic [wordWidth-1:0] mStoreData;
    logic wValid;
    logic [regAddrWidth-1:0] wDest;
    logic [wordWidth-1:0] wValue;

    always_ff @(posedge clk) begin
        if (reset) begin
            mValid <= 1'b0;
            mMemRead <= 1'b0;
            mMemWrite <= 1'b0;
            mDest <= '0;
            wValid <= 1'b0;
            wDest <= '0;
        end
        else begin
            mValid <= fromExecute.valid;
            mMemRead <= fromExecute.memRead;
            mMemWrite <= fromExecute.memWrite;
            mDest <= fromExecute.dest;
            wValid <= mValid;
            wDest <= mDest;
        end
    end

    // Memory answers in the same cycle, so the load result is taken here
    always_ff @(posedge clk) begin
        mAluResult <= fromExecute.aluResult;
        mStoreData <= fromExecute.storeData;
        wValue <= mMemRead ? dataReadData : mAluResult;
    end

    assign dataAddr = mAluResult;
    assign dataWriteData = mStoreData;
    assign dataReadEnable = mValid && mMemRead;
    assign dataWriteEnable = mValid && mMemWrite;

    assign writeAddr = wValid ? wDest : '0;
    assign writeData = wValue;

    assign bypass.memValid = mValid;
    assign bypass.memLoad = mMemRead;
    assign bypass.memDest = mDest;
    assign bypass.memValue = mAluResult;
    assign bypass.wbValid = wValid;
    assign bypass.wbDest = wDest;
    assign bypass.wbValue = wValue;

    oneStrobe: assert property (@(posedge clk) disable iff (reset)
        !(dataReadEnable && dataWriteEnable));

endmodule

/* executeStage.sv */
`timescale 1ns/1ps

module executeStage import cpuPkg::*; (
    input  logic clk,
    input  logic reset,
    decodeExIf.executeSide fromDecode,
    exMemIf.executeSide toMemory,
    bypassIf.exSide bypass
);

    logic xValid;
    logic xMemRead;
    logic xMemWrite;
    logic [regAddrWidth-1:0] xDest;
    logic [aluOpWidth-1:0] xAluOp;
    logic [wordWidth-1:0] xA;
    logic [wordWidth-1:0] xB;
    logic [wordWidth-1:0] xStore;
    logic [wordWidth-1:0] result;

    always_ff @(posedge clk) begin
        if (reset) begin
            xValid <= 1'b0;
            xMemRead <= 1'b0;
            xMemWrite <= 1'b0;
            xDest <= '0;
        end
        else begin
            xValid <= fromDecode.valid;
            xMemRead <= fromDecode.memRead;
            xMemWrite <= fromDecode.memWrite;
            xDest <= fromDecode.dest;
        end
    end

    always_ff @(posedge clk) begin
        xAluOp <= fromDecode.aluOp;
        xA <= fromDecode.operandA;
        xB <= fromDecode.operandB;
        xStore <= fromDecode.storeData;
    end

    always_comb begin
        case (xAluOp)
            aluAddu: result = xA + xB;
            aluSubu: result = xA - xB;
            aluAnd: result = xA & xB;
            aluOr: result = xA | xB;
            aluSlt: result = {{(wordWidth-1){1'b0}}, $signed(xA) < $signed(xB)};
            aluOri: result = xA | {{(wordWidth-16){1'b0}}, xB[15:0]};
            aluLui: result = {xB[15:0], {(wordWidth-16){1'b0}}};
            default: result = '0;
        endcase
    end

    // Also the load and store address
    assign toMemory.valid = xValid;
    assign toMemory.aluResult = result;
    assign toMemory.storeData = xStore;
    assign toMemory.dest = xDest;
    assign toMemory.memRead = xMemRead;
    assign toMemory.memWrite = xMemWrite;

    // Load data is not known here, so decode must wait
    assign bypass.exValid = xValid && !xMemRead;
    assign bypass.exDest = xValid ? xDest : '0;
    assign bypass.exValue = result;

endmodule

/* decodeStage.sv */
`timescale 1ns/1ps

module decodeStage import cpuPkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic [wordWidth-1:0] instrData,
    input  logic [wordWidth-1:0] instrAddr,
    output logic stall,
    output logic redirect,
    output logic [wordWidth-1:0] redirectPc,
    output logic [regAddrWidth-1:0] readAddr1,
    output logic [regAddrWidth-1:0] readAddr2,
    input  logic [wordWidth-1:0] readData1,
    input  logic [wordWidth-1:0] readData2,
    decodeExIf.decodeSide toExecute,
    bypassIf.decodeSide bypass
);

    logic dValid;
    instrWord dInstr;
    logic [wordWidth-1:0] dPc;
    logic [wordWidth-1:0] immExt;
    logic [wordWidth:0] fwdA;
    logic [wordWidth:0] fwdB;
    logic [wordWidth-1:0] opA;
    logic [wordWidth-1:0] opB;
    logic useRs, useRt, useImm;
    logic isBeq, isBne, isJump;
    logic memRead, memWrite;
    logic [aluOpWidth-1:0] aluOp;
    logic [regAddrWidth-1:0] dest;
    logic branchTaken;
    logic issue;

    always_ff @(posedge clk) begin
        if (reset) begin
            dValid <= 1'b0;
        end
        else if (!stall) begin
            dValid <= 1'b1;
            dInstr <= instrData;
            dPc <= instrAddr;
        end
    end

    // Top bit flags a load result that is not back yet; later checks are younger
    function automatic logic [wordWidth:0] forwardOperand(
        input logic [regAddrWidth-1:0] idx,
        input logic [wordWidth-1:0] fileValue
    );
        logic [wordWidth:0] result;
        result = {1'b0, fileValue};
        if (idx != '0) begin
            if (bypass.wbValid && bypass.wbDest == idx) begin
                result = {1'b0, bypass.wbValue};
            end
            if (bypass.memValid && bypass.memDest == idx) begin
                result = {bypass.memLoad, bypass.memValue};
            end
            if (bypass.exDest == idx) begin
                result = {!bypass.exValid, bypass.exValue};
            end
        end
        return result;
    endfunction

    assign readAddr1 = dInstr.i.rs;
    assign readAddr2 = dInstr.i.rt;
    assign fwdA = forwardOperand(dInstr.i.rs, readData1);
    assign fwdB = forwardOperand(dInstr.i.rt, readData2);
    assign opA = fwdA[wordWidth-1:0];
    assign opB = fwdB[wordWidth-1:0];
    assign immExt = {{(wordWidth-16){dInstr.i.imm[15]}}, dInstr.i.imm};

    always_comb begin
        useRs = 1'b0;
        useRt = 1'b0;
        useImm = 1'b1;
        isBeq = 1'b0;
        isBne = 1'b0;
        isJump = 1'b0;
        memRead = 1'b0;
        memWrite = 1'b0;
        aluOp = aluAddu;
        dest = '0;
        case (dInstr.r.opcode)
            opSpecial: begin
                useRs = 1'b1;
                useRt = 1'b1;
                useImm = 1'b0;
                dest = dInstr.r.rd;
                case (dInstr.r.funct)
                    fnAddu: aluOp = aluAddu;
                    fnSubu: aluOp = aluSubu;
                    fnAnd: aluOp = aluAnd;
                    fnOr: aluOp = aluOr;
                    fnSlt: aluOp = aluSlt;
                    default: dest = '0;
                endcase
            end
            opOri: begin
                useRs = 1'b1;
                aluOp = aluOri;
                dest = dInstr.i.rt;
            end
            opLui: begin
                aluOp = aluLui;
                dest = dInstr.i.rt;
            end
            opLw: begin
                useRs = 1'b1;
                memRead = 1'b1;
                dest = dInstr.i.rt;
            end
            opSw: begin
                useRs = 1'b1;
                useRt = 1'b1;
                memWrite = 1'b1;
            end
            opBeq: begin
                useRs = 1'b1;
                useRt = 1'b1;
                isBeq = 1'b1;
            end
            opBne: begin
                useRs = 1'b1;
                useRt = 1'b1;
                isBne = 1'b1;
            end
            opJ: isJump = 1'b1;
            default: ;
        endcase
    end

    assign stall = dValid && ((useRs && fwdA[wordWidth]) || (useRt && fwdB[wordWidth]));
    assign issue = dValid && !stall;

    assign branchTaken = (isBeq && opA == opB) || (isBne && opA != opB);
    // Branches need both compare operands resolved, jumps need none
    assign redirect = dValid &&
        (isJump || (branchTaken && !fwdA[wordWidth] && !fwdB[wordWidth]));
    assign redirectPc = isJump ?
        {dPc[wordWidth-1:wordWidth-4], dInstr.r.rs, dInstr.r.rt, dInstr.r.rd,
         dInstr.r.shamt, dInstr.r.funct, 2'b00} :
        dPc + wordWidth'(4) + {immExt[wordWidth-3:0], 2'b00};

    // Bubble into execute while stalled
    assign toExecute.valid = issue;
    assign toExecute.aluOp = aluOp;
    assign toExecute.operandA = opA;
    assign toExecute.operandB = useImm ? immExt : opB;
    assign toExecute.storeData = opB;
    assign toExecute.dest = issue ? dest : '0;
    assign toExecute.memRead = issue && memRead;
    assign toExecute.memWrite = issue && memWrite;

    noRedirectOnStall: assert property (@(posedge clk) disable iff (reset)
        !(redirect && stall));

endmodule

/* registerFile.sv */
`timescale 1ns/1ps

module registerFile import cpuPkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic [regAddrWidth-1:0] readAddr1,
    input  logic [regAddrWidth-1:0] readAddr2,
    output logic [wordWidth-1:0] readData1,
    output logic [wordWidth-1:0] readData2,
    input  logic [regAddrWidth-1:0] writeAddr,
    input  logic [wordWidth-1:0] writeData
);

    localparam int regCount = 1 << regAddrWidth;

    logic [wordWidth-1:0] regs [regCount];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int idx = 0; idx < regCount; idx++) begin
                regs[idx] <= '0;
            end
        end
        else if (writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Write-through so decode sees the value retiring this cycle
    assign readData1 = (writeAddr != '0 && readAddr1 == writeAddr) ? writeData :
                       regs[readAddr1];
    assign readData2 = (writeAddr != '0 && readAddr2 == writeAddr) ? writeData :
                       regs[readAddr2];

    zeroReg: assert property (@(posedge clk) disable iff (reset)
        (readAddr1 == '0 |-> readData1 == '0) and (readAddr2 == '0 |-> readData2 == '0));

endmodule

/* fetchUnit.sv */
`timescale 1ns/1ps

module fetchUnit import cpuPkg::*; #(
    parameter logic [wordWidth-1:0] resetPc = '0
) (
    input  logic clk,
    input  logic reset,
    input  logic stall,
    input  logic redirect,
    input  logic [wordWidth-1:0] redirectPc,
    output logic [wordWidth-1:0] instrAddr
);

    logic [wordWidth-1:0] pc;

    // Redirect wins; decode never raises it while stalled
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= resetPc;
        end
        else if (redirect) begin
            pc <= redirectPc;
        end
        else if (!stall) begin
            pc <= pc + wordWidth'(4);
        end
    end

    assign instrAddr = pc;

    // Branch and jump targets from decode keep word alignment
    pcAligned: assert property (@(posedge clk) disable iff (reset)
        pc[1:0] == 2'b00);

endmodule

/* pipeIf.sv */
`timescale 1ns/1ps

interface decodeExIf import cpuPkg::*; ();
    logic valid;
    logic [aluOpWidth-1:0] aluOp;
    logic [wordWidth-1:0] operandA;
    logic [wordWidth-1:0] operandB;
    logic [wordWidth-1:0] storeData;
    logic [regAddrWidth-1:0] dest;
    logic memRead;
    logic memWrite;

    modport decodeSide (output valid, aluOp, operandA, operandB, storeData, dest,
                        memRead, memWrite);
    modport executeSide (input valid, aluOp, operandA, operandB, storeData, dest,
                         memRead, memWrite);
endinterface

interface exMemIf import cpuPkg::*; ();
    logic valid;
    logic [wordWidth-1:0] aluResult;
    logic [wordWidth-1:0] storeData;
    logic [regAddrWidth-1:0] dest;
    logic memRead;
    logic memWrite;

    modport executeSide (output valid, aluResult, storeData, dest, memRead, memWrite);
    modport memorySide (input valid, aluResult, storeData, dest, memRead, memWrite);
endinterface

// Result sources that decode may forward from
interface bypassIf import cpuPkg::*; ();
    logic exValid;
    logic [regAddrWidth-1:0] exDest;
    logic [wordWidth-1:0] exValue;
    logic memValid;
    logic memLoad;
    logic [regAddrWidth-1:0] memDest;
    logic [wordWidth-1:0] memValue;
    logic wbValid;
    logic [regAddrWidth-1:0] wbDest;
    logic [wordWidth-1:0] wbValue;

    modport exSide (output exValid, exDest, exValue);
    modport lateSide (output memValid, memLoad, memDest, memValue, wbValid, wbDest, wbValue);
    modport decodeSide (input exValid, exDest, exValue, memValid, memLoad, memDest,
                        memValue, wbValid, wbDest, wbValue);
endinterface

/* cpuPkg.sv */
package cpuPkg;

    localparam int wordWidth = 32;
    localparam int regAddrWidth = 5;
    localparam int aluOpWidth = 3;

    // Primary opcodes
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opJ = 6'h02;
    localparam logic [5:0] opBeq = 6'h04;
    localparam logic [5:0] opBne = 6'h05;
    localparam logic [5:0] opOri = 6'h0d;
    localparam logic [5:0] opLui = 6'h0f;
    localparam logic [5:0] opLw = 6'h23;
    localparam logic [5:0] opSw = 6'h2b;

    // Function field of the special opcode
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd = 6'h24;
    localparam logic [5:0] fnOr = 6'h25;
    localparam logic [5:0] fnSlt = 6'h2a;

    localparam logic [aluOpWidth-1:0] aluAddu = 3'd0;
    localparam logic [aluOpWidth-1:0] aluSubu = 3'd1;
    localparam logic [aluOpWidth-1:0] aluAnd = 3'd2;
    localparam logic [aluOpWidth-1:0] aluOr = 3'd3;
    localparam logic [aluOpWidth-1:0] aluSlt = 3'd4;
    // Zero-extends the low half of operand B
    localparam logic [aluOpWidth-1:0] aluOri = 3'd5;
    localparam logic [aluOpWidth-1:0] aluLui = 3'd6;

    // Register and immediate views of one instruction word
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [regAddrWidth-1:0] rs;
            logic [regAddrWidth-1:0] rt;
            logic [regAddrWidth-1:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0] opcode;
            logic [regAddrWidth-1:0] rs;
            logic [regAddrWidth-1:0] rt;
            logic [15:0] imm;
        } i;
    } instrWord;

endpackage
